//--- all.f
logic/win_pkg.sv
logic/line_buffer.sv
logic/window_shift.sv
logic/raster_tracker.sv
logic/border_pad.sv
logic/window_5x5_top.sv
sim/window_checker.sv
sim/tb_window.sv

//--- logic/border_pad.sv
`timescale 1ns/1ps

module border_pad
    import win_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                emit_i,
    input  logic                last_i,
    input  logic [ROW_W-1:0]    ctr_row_i,
    input  logic [COL_W-1:0]    ctr_col_i,
    input  logic [WIN_BITS-1:0] raw_win_i,
    output logic [WIN_BITS-1:0] win_o,
    output logic                win_valid_o,
    output logic                frame_done_o
);

    logic [WIN-1:0] row_ok;
    logic [WIN-1:0] col_ok;
    logic [WIN-1:0][WIN-1:0][PIX_W-1:0] pad_win;

    // window row dy maps to image row ctr_row_i + dy - HALF
    // offset by HALF on both sides so nothing goes negative
    always_comb begin
        for (int dy = 0; dy < WIN; dy++) begin
            row_ok[dy] = (int'(ctr_row_i) + dy >= HALF)
                && (int'(ctr_row_i) + dy < ROWS + HALF);
        end
    end

    always_comb begin
        for (int dx = 0; dx < WIN; dx++) begin
            col_ok[dx] = (int'(ctr_col_i) + dx >= HALF)
                && (int'(ctr_col_i) + dx < COLS + HALF);
        end
    end

    // off-image positions read as zero
    // this also hides stale lines and columns wrapped from the previous row
    always_comb begin
        for (int dy = 0; dy < WIN; dy++) begin
            for (int dx = 0; dx < WIN; dx++) begin
                if (row_ok[dy] && col_ok[dx]) begin
                    pad_win[dy][dx] = raw_win_i[(dy*WIN + dx)*PIX_W +: PIX_W];
                end else begin
                    pad_win[dy][dx] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            win_o <= '0;
            win_valid_o <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            win_valid_o <= emit_i;
            frame_done_o <= last_i;
            // hold the last window between emits
            if (emit_i) begin
                win_o <= pad_win;
            end
        end
    end

endmodule

//--- logic/line_buffer.sv
`timescale 1ns/1ps

module line_buffer
    import win_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                shift_i,
    input  logic                flush_i,
    input  logic [PIX_W-1:0]    pix_i,
    output logic [COL_BITS-1:0] col_o
);

    // tap[WIN-1] is the incoming pixel, tap[0] the one four rows back
    logic [WIN-1:0][PIX_W-1:0] tap;

    // zeros go in behind the last pixel of the frame
    assign tap[WIN-1] = flush_i ? '0 : pix_i;

    genvar g;
    generate
        for (g = 0; g < WIN - 1; g++) begin : g_line
            logic [PIX_W-1:0] dly_q [COLS];

            // one row of delay, fed from the next newer tap
            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int j = 0; j < COLS; j++) begin
                        dly_q[j] <= '0;
                    end
                end else if (shift_i) begin
                    dly_q[0] <= tap[g+1];
                    for (int j = 1; j < COLS; j++) begin
                        dly_q[j] <= dly_q[j-1];
                    end
                end
            end

            // tail holds the value pushed exactly COLS steps ago
            assign tap[g] = dly_q[COLS-1];
        end
    endgenerate

    assign col_o = tap;

endmodule

//--- logic/raster_tracker.sv
`timescale 1ns/1ps

module raster_tracker
    import win_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             pix_valid_i,
    output logic             in_ready_o,
    output logic             shift_o,
    output logic             flush_o,
    output logic             emit_o,
    output logic             last_o,
    output logic [ROW_W-1:0] ctr_row_o,
    output logic [COL_W-1:0] ctr_col_o
);

    // stream index within the frame, pixels then flush steps
    logic [STEP_W-1:0] step_q;

    // centre of the next window to emit
    logic [ROW_W-1:0] pos_row_q;
    logic [COL_W-1:0] pos_col_q;

    logic accept;
    logic emit_now;
    logic pos_row_end;
    logic pos_col_end;

    assign in_ready_o = (step_q < STEP_W'(FRAME_PIX));
    assign flush_o = ~in_ready_o;
    assign accept = pix_valid_i & in_ready_o;
    assign shift_o = accept | flush_o;

    // the centre trails the newest pixel by FLUSH_STEPS
    assign emit_now = shift_o && (step_q >= STEP_W'(FLUSH_STEPS));

    assign pos_row_end = (pos_row_q == ROW_W'(ROWS - 1));
    assign pos_col_end = (pos_col_q == COL_W'(COLS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            step_q <= '0;
        end else if (shift_o) begin
            if (step_q == STEP_W'(FRAME_STEPS - 1)) begin
                step_q <= '0;
            end else begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    // raster walk of the centre, one step per emitted window
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_row_q <= '0;
            pos_col_q <= '0;
        end else if (emit_now) begin
            if (pos_col_end) begin
                pos_col_q <= '0;
                pos_row_q <= pos_row_end ? '0 : pos_row_q + 1'b1;
            end else begin
                pos_col_q <= pos_col_q + 1'b1;
            end
        end
    end

    // flags describe the window that window_shift holds after this edge
    always_ff @(posedge clk) begin
        if (rst) begin
            emit_o <= 1'b0;
            last_o <= 1'b0;
            ctr_row_o <= '0;
            ctr_col_o <= '0;
        end else begin
            emit_o <= emit_now;
            last_o <= emit_now & pos_row_end & pos_col_end;
            if (emit_now) begin
                ctr_row_o <= pos_row_q;
                ctr_col_o <= pos_col_q;
            end
        end
    end

endmodule

//--- logic/win_pkg.sv
package win_pkg;

    // pixel and window geometry
    localparam int PIX_W = 8;
    localparam int WIN = 5;
    localparam int HALF = 2;

    // one vertical column of the window, oldest row in the low slot
    localparam int COL_BITS = WIN * PIX_W;

    // whole window, row-major, position (dy,dx) at index dy*WIN+dx
    localparam int WIN_BITS = WIN * WIN * PIX_W;

    // frame size
    localparam int ROWS = 8;
    localparam int COLS = 12;

    // centre position counters
    localparam int ROW_W = $clog2(ROWS);
    localparam int COL_W = $clog2(COLS);

    localparam int FRAME_PIX = ROWS * COLS;

    // zero steps after the last pixel so the centre reaches the last pixel
    localparam int FLUSH_STEPS = 2 * COLS + 2;

    // stream steps per frame, pixels followed by flush
    localparam int FRAME_STEPS = FRAME_PIX + FLUSH_STEPS;
    localparam int STEP_W = $clog2(FRAME_STEPS);

endpackage

//--- logic/window_5x5_top.sv
`timescale 1ns/1ps

module window_5x5_top
    import win_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                pix_valid_i,
    input  logic [PIX_W-1:0]    pix_i,
    output logic                in_ready_o,
    output logic [WIN_BITS-1:0] win_o,
    output logic                win_valid_o,
    output logic                frame_done_o
);

    logic                shift;
    logic                flush;
    logic                emit;
    logic                last;
    logic [ROW_W-1:0]    ctr_row;
    logic [COL_W-1:0]    ctr_col;
    logic [COL_BITS-1:0] col;
    logic [WIN_BITS-1:0] raw_win;

    raster_tracker u_tracker (
        .clk         (clk),
        .rst         (rst),
        .pix_valid_i (pix_valid_i),
        .in_ready_o  (in_ready_o),
        .shift_o     (shift),
        .flush_o     (flush),
        .emit_o      (emit),
        .last_o      (last),
        .ctr_row_o   (ctr_row),
        .ctr_col_o   (ctr_col)
    );

    line_buffer u_lines (
        .clk     (clk),
        .rst     (rst),
        .shift_i (shift),
        .flush_i (flush),
        .pix_i   (pix_i),
        .col_o   (col)
    );

    // advances on the same edge as the line buffer
    window_shift u_window (
        .clk       (clk),
        .rst       (rst),
        .shift_i   (shift),
        .col_i     (col),
        .raw_win_o (raw_win)
    );

    border_pad u_pad (
        .clk          (clk),
        .rst          (rst),
        .emit_i       (emit),
        .last_i       (last),
        .ctr_row_i    (ctr_row),
        .ctr_col_i    (ctr_col),
        .raw_win_i    (raw_win),
        .win_o        (win_o),
        .win_valid_o  (win_valid_o),
        .frame_done_o (frame_done_o)
    );

endmodule

//--- logic/window_shift.sv
`timescale 1ns/1ps

module window_shift
    import win_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                shift_i,
    input  logic [COL_BITS-1:0] col_i,
    output logic [WIN_BITS-1:0] raw_win_o
);

    // win_q[dy][dx] lands at index dy*WIN+dx of the flat window
    logic [WIN-1:0][WIN-1:0][PIX_W-1:0] win_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            win_q <= '0;
        end else if (shift_i) begin
            for (int dy = 0; dy < WIN; dy++) begin
                // older columns move left
                for (int dx = 0; dx < WIN - 1; dx++) begin
                    win_q[dy][dx] <= win_q[dy][dx+1];
                end
                // newest column enters on the right
                win_q[dy][WIN-1] <= col_i[dy*PIX_W +: PIX_W];
            end
        end
    end

    assign raw_win_o = win_q;

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_window \
    -f all.f -o tb_window &&
    ./obj_dir/tb_window > sim.log 2>&1 ||
    echo "build or simulation stopped with an error"
[ -f sim.log ] && cat sim.log
grep -q "Result: PASSED" sim.log 2>/dev/null && exit 0 || exit 1

//--- sim/tb_window.sv
`timescale 1ns/1ps

module tb_window
    import win_pkg::*;
();

    localparam int NUM_FRAMES = 4;
    localparam int SEED = 53;
    localparam int LIMIT_CYCLES = NUM_FRAMES * (FRAME_PIX*4 + FLUSH_STEPS + 20);

    logic                clk;
    logic                rst;
    logic                pix_valid;
    logic [PIX_W-1:0]    pix;
    logic                in_ready;
    logic [WIN_BITS-1:0] win;
    logic                win_valid;
    logic                frame_done;

    int data_errs;
    int proto_errs;
    int win_count;
    int frames_seen;
    int count_errs;

    window_5x5_top DUT (
        .clk          (clk),
        .rst          (rst),
        .pix_valid_i  (pix_valid),
        .pix_i        (pix),
        .in_ready_o   (in_ready),
        .win_o        (win),
        .win_valid_o  (win_valid),
        .frame_done_o (frame_done)
    );

    window_checker u_checker (
        .clk           (clk),
        .rst           (rst),
        .pix_valid_i   (pix_valid),
        .pix_i         (pix),
        .in_ready_i    (in_ready),
        .win_i         (win),
        .win_valid_i   (win_valid),
        .frame_done_i  (frame_done),
        .data_errs_o   (data_errs),
        .proto_errs_o  (proto_errs),
        .win_count_o   (win_count),
        .frames_seen_o (frames_seen)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one random frame, each pixel held until it is taken
    task automatic send_frame();
        logic [PIX_W-1:0] px;
        logic sent;
        for (int i = 0; i < FRAME_PIX; i++) begin
            px = PIX_W'($urandom);
            sent = 1'b0;
            while (!sent) begin
                @(posedge clk);
                #1;
                pix_valid = (($urandom % 100) < 70);
                // junk on the bus while valid is low
                pix = pix_valid ? px : PIX_W'($urandom);
                @(negedge clk);
                sent = pix_valid && in_ready;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        pix_valid = 1'b0;
        pix = '0;
        count_errs = 0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame();
        end
        @(posedge clk);
        #1;
        pix_valid = 1'b0;
        wait (frames_seen == NUM_FRAMES);
        // give stray windows a chance to show up
        repeat (20) @(posedge clk);
        if (win_count != NUM_FRAMES * FRAME_PIX) begin
            $display("got %0d windows where %0d were due", win_count, NUM_FRAMES * FRAME_PIX);
            count_errs++;
        end
        $display("errors: data %0d, protocol %0d, count %0d over %0d windows",
            data_errs, proto_errs, count_errs, win_count);
        if (data_errs == 0 && proto_errs == 0 && count_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMIT_CYCLES + 8) @(posedge clk);
        $display("timeout: %0d of %0d frames finished after %0d cycles",
            frames_seen, NUM_FRAMES, LIMIT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sim/window_checker.sv
`timescale 1ns/1ps

module window_checker
    import win_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                pix_valid_i,
    input  logic [PIX_W-1:0]    pix_i,
    input  logic                in_ready_i,
    input  logic [WIN_BITS-1:0] win_i,
    input  logic                win_valid_i,
    input  logic                frame_done_i,
    output int                  data_errs_o,
    output int                  proto_errs_o,
    output int                  win_count_o,
    output int                  frames_seen_o
);

    // two model images picked by frame parity
    logic [PIX_W-1:0] img [2][FRAME_PIX];

    int acc_total;
    int low_left;

    function automatic logic [PIX_W-1:0] model_pixel(int bank, int r, int c);
        if (r < 0 || r >= ROWS || c < 0 || c >= COLS) begin
            return '0;
        end
        return img[bank][r*COLS + c];
    endfunction

    // in_ready must drop for exactly FLUSH_STEPS cycles after a frame
    task automatic check_ready();
        if (low_left > 0) begin
            if (in_ready_i) begin
                $display("Fail t=%0t: in_ready_o high during flush", $time);
                proto_errs_o++;
            end
            low_left--;
        end else if (!in_ready_i) begin
            $display("Fail t=%0t: in_ready_o low outside flush", $time);
            proto_errs_o++;
        end
    endtask

    task automatic check_window();
        int f;
        int k;
        int row;
        int col;
        int need;
        logic [PIX_W-1:0] got;
        logic [PIX_W-1:0] exp;
        logic bad;
        f = win_count_o / FRAME_PIX;
        k = win_count_o % FRAME_PIX;
        row = k / COLS;
        col = k % COLS;
        bad = 1'b0;
        need = f*FRAME_PIX;
        if (k + FLUSH_STEPS + 1 < FRAME_PIX) begin
            need = need + k + FLUSH_STEPS + 1;
        end else begin
            need = need + FRAME_PIX;
        end
        if (acc_total < need) begin
            $display("window %0d of frame %0d came out before its pixels went in", k, f);
            proto_errs_o++;
        end else begin
            for (int dy = 0; dy < WIN; dy++) begin
                for (int dx = 0; dx < WIN; dx++) begin
                    got = win_i[(dy*WIN + dx)*PIX_W +: PIX_W];
                    exp = model_pixel(f % 2, row + dy - HALF, col + dx - HALF);
                    if (!bad && got !== exp) begin
                        $display({"Fail t=%0t: frame %0d centre (%0d,%0d) pos (%0d,%0d)",
                            " got %02h expected %02h"},
                            $time, f, row, col, dy, dx, got, exp);
                        bad = 1'b1;
                    end
                end
            end
            if (bad) begin
                data_errs_o++;
            end
        end
        if (frame_done_i !== (k == FRAME_PIX - 1)) begin
            $display("Fail t=%0t: frame_done_o is %0b at window %0d of frame %0d",
                $time, frame_done_i, k, f);
            proto_errs_o++;
        end
        if (k == FRAME_PIX - 1) begin
            frames_seen_o++;
        end
        win_count_o++;
    endtask

    // everything is stable at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            acc_total = 0;
            low_left = 0;
            data_errs_o = 0;
            proto_errs_o = 0;
            win_count_o = 0;
            frames_seen_o = 0;
            if (win_valid_i === 1'b1 || frame_done_i === 1'b1) begin
                $display("Fail t=%0t: output flags are high while reset is held", $time);
                proto_errs_o++;
            end
        end else begin
            check_ready();
            if (win_valid_i) begin
                check_window();
            end else if (frame_done_i) begin
                $display("Fail t=%0t: frame_done_o went high without a valid window", $time);
                proto_errs_o++;
            end
            // acceptance happens at the coming rising edge
            if (pix_valid_i && in_ready_i) begin
                img[(acc_total / FRAME_PIX) % 2][acc_total % FRAME_PIX] = pix_i;
                if (acc_total % FRAME_PIX == FRAME_PIX - 1) begin
                    low_left = FLUSH_STEPS;
                end
                acc_total++;
            end
        end
    end

endmodule
